/* project.f */
+incdir+include
source/ulpi_pkg.sv
source/ulpi_if.sv
source/usb_crc16.sv
source/ulpi_tx_encoder.sv
source/ulpi_reg_apb.sv
source/ulpi_tx_top.sv
sim/ulpi_tx_assert.sv
sim/ulpi_tx_tb.sv

/* Makefile */
# Verilator build for the ULPI transmit controller
VERILATOR ?= verilator
TOP       ?= ulpi_tx_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/ulpi_tx_tb.sv */
`timescale 1ns/100ps
`include "ulpi_settings.svh"

module ulpi_tx_tb;

  // Marker in the byte logs for an STP cycle
  localparam int STP_MARK = 256;

  logic                    clock, reset;
  logic                    psel_i, penable_i, pwrite_i;
  logic [`ULPI_APB_AW-1:0] paddr_i;
  logic [31:0]             pwdata_i, prdata_o;
  logic                    pready_o, pslverr_o;
  logic                    s_tvalid_i, s_tready_o, s_tlast_i;
  logic [3:0]              s_tpid_i;
  logic [7:0]              s_tdata_i;
  logic [1:0]              line_state_i;
  logic                    ulpi_dir_i, ulpi_nxt_i, ulpi_stp_o;
  logic [7:0]              ulpi_data_o;

  // PHY model state
  logic                phy_active, nxt_hold;
  ulpi_pkg::ulpi_cmd_e phy_cmd;
  int                  eop_cnt;

  int         log_q[$];
  int         exp_q[$];
  logic [7:0] payload[$];
  logic [7:0] exp_count;
  int         data_errors, apb_errors, other_errors;
  int         cycles, limit;

  ulpi_tx_top i_dut (.*);

  always #2 clock = ~clock;

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  function automatic logic [`ULPI_APB_AW-1:0] reg_addr(input ulpi_pkg::apb_reg_e r);
    return {2'b00, r};
  endfunction

  // USB CRC16, reflected form of 8005, sent inverted
  function automatic logic [15:0] crc16_ref();
    logic [15:0] c;
    c = `ULPI_CRC_SEED;
    foreach (payload[i]) begin
      c = c ^ {8'h00, payload[i]};
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? ((c >> 1) ^ 16'hA001) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  function automatic void push_exp(input logic [7:0] b);
    exp_q.push_back(int'(b));
  endfunction

  // Packet: TX command, payload, CRC low then high, STP
  function automatic void expect_packet(input logic [3:0] pid);
    logic [15:0] crc;
    crc = crc16_ref();
    push_exp({ulpi_pkg::CMD_TX, 2'b00, pid});
    foreach (payload[i]) push_exp(payload[i]);
    push_exp(crc[7:0]);
    push_exp(crc[15:8]);
    exp_q.push_back(STP_MARK);
  endfunction

  function automatic void expect_regw(input logic [5:0] addr, input logic [7:0] data);
    push_exp({ulpi_pkg::CMD_REGW, addr});
    push_exp(data);
    exp_q.push_back(STP_MARK);
    exp_count = exp_count + 8'd1;
  endfunction

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      data_errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_cmd(input ulpi_pkg::ulpi_cmd_e got, input ulpi_pkg::ulpi_cmd_e exp);
    if (got !== exp) begin
      data_errors++;
      $display("ERR ulpi_data_o[7:6] got %h expected %h", got, exp);
    end
  endtask

  task automatic check_apb(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      apb_errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  // One APB transfer, waits counts stretched access cycles
  task automatic apb_access(input logic wr, input logic [`ULPI_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int waits);
    waits = 0;
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clock);
    penable_i <= 1'b1;
    @(posedge clock);
    while (!pready_o) begin
      waits++;
      @(posedge clock);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic apb_write(input ulpi_pkg::apb_reg_e r, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    int          waits;
    apb_access(1'b1, reg_addr(r), wdata, rd, err, waits);
    check_apb("pslverr_o", {31'd0, err}, 32'd0);
  endtask

  task automatic check_status();
    logic [31:0] rd;
    logic        err;
    int          waits;
    apb_access(1'b0, reg_addr(ulpi_pkg::REG_STATUS), 32'd0, rd, err, waits);
    check_apb("prdata_o", rd, {16'd0, exp_count, 8'd0});
  endtask

  task automatic make_payload(input int len);
    payload.delete();
    for (int i = 0; i < len; i++) payload.push_back(rand_byte());
  endtask

  // Stream the current payload, first byte driven on this edge
  task automatic send_packet(input logic [3:0] pid);
    int idx;
    idx = 0;
    s_tvalid_i <= 1'b1;
    s_tpid_i   <= pid;
    s_tdata_i  <= payload[0];
    s_tlast_i  <= payload.size() == 1;
    while (idx < payload.size()) begin
      @(posedge clock);
      if (s_tvalid_i && s_tready_o) begin
        idx++;
        if (idx < payload.size()) begin
          s_tdata_i <= payload[idx];
          s_tlast_i <= idx == payload.size() - 1;
        end else begin
          s_tvalid_i <= 1'b0;
          s_tlast_i  <= 1'b0;
        end
      end
    end
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0 || log_q.size() != 0 || phy_active || eop_cnt != 0) begin
      @(posedge clock);
    end
    repeat (4) @(posedge clock);
  endtask

  task automatic run_packet(input int len);
    logic [7:0] pid;
    pid = rand_byte();
    make_payload(len);
    expect_packet(pid[3:0]);
    send_packet(pid[3:0]);
    wait_idle();
  endtask

  // PHY: random nxt while transmitting, EOP turnaround after packet STP
  always @(posedge clock) begin : phy_model
    logic [7:0] r;
    r = rand_byte();
    if (reset) begin
      ulpi_nxt_i   <= 1'b0;
      ulpi_dir_i   <= 1'b0;
      line_state_i <= 2'b01;
      phy_active   <= 1'b0;
      eop_cnt      <= 0;
    end else if (eop_cnt != 0) begin
      if (eop_cnt == 1) begin
        ulpi_dir_i   <= 1'b0;
        line_state_i <= 2'b01;
      end
      eop_cnt <= eop_cnt - 1;
    end else if (!phy_active) begin
      // Any nonzero byte in idle opens a transmit or register write
      if (!ulpi_dir_i && !ulpi_stp_o && ulpi_data_o != 8'h00) begin
        phy_active <= 1'b1;
        phy_cmd    <= ulpi_pkg::ulpi_cmd_e'(ulpi_data_o[7:6]);
        ulpi_nxt_i <= !nxt_hold && r[1:0] != 2'b00;
      end
    end else begin
      if (ulpi_nxt_i && !ulpi_dir_i && !ulpi_stp_o) log_q.push_back(int'(ulpi_data_o));
      if (ulpi_stp_o) begin
        log_q.push_back(STP_MARK);
        phy_active <= 1'b0;
        ulpi_nxt_i <= 1'b0;
        if (phy_cmd == ulpi_pkg::CMD_TX) begin
          ulpi_dir_i   <= 1'b1;
          line_state_i <= `ULPI_EOP_LS;
          eop_cnt      <= 4;
        end
      end else begin
        ulpi_nxt_i <= !nxt_hold && r[1:0] != 2'b00;
      end
    end
  end

  // Compare logged PHY bytes against the reference list
  always @(negedge clock) begin : compare_bytes
    int   got;
    int   exp;
    logic first;
    if (reset) first = 1'b1;
    while (log_q.size() > 0) begin
      got = log_q.pop_front();
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("PHY accepted byte %h with no byte left to expect", got);
      end else begin
        exp = exp_q.pop_front();
        if (got == STP_MARK || exp == STP_MARK) begin
          if (got != exp) begin
            other_errors++;
            $display("STP out of place, PHY log %h against expected %h", got, exp);
          end
        end else begin
          check_byte("ulpi_data_o", got[7:0], exp[7:0]);
          if (first) check_cmd(ulpi_pkg::ulpi_cmd_e'(got[7:6]), ulpi_pkg::ulpi_cmd_e'(exp[7:6]));
        end
        first = exp == STP_MARK;
      end
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Errors: data %0d, apb %0d, other %0d", data_errors, apb_errors, other_errors);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    int          lens[6];
    int          total;
    int          waits;
    logic [31:0] rd;
    logic        err;
    logic [7:0]  a1, d1, a2, d2;
    void'($urandom(32'h5cab_78d8));
    clock = 1'b0;
    reset = 1'b1;
    {psel_i, penable_i, pwrite_i, paddr_i, pwdata_i} = '0;
    {s_tvalid_i, s_tlast_i, s_tpid_i, s_tdata_i} = '0;
    {ulpi_dir_i, ulpi_nxt_i} = 2'b00;
    line_state_i = 2'b01;
    {phy_active, nxt_hold, eop_cnt} = '0;
    phy_cmd = ulpi_pkg::CMD_NOOP;
    {data_errors, apb_errors, other_errors, cycles} = '0;
    exp_count = 8'd0;
    // Lengths fixed up front so the timeout follows the test size
    total = 4 * 2;
    foreach (lens[i]) begin
      lens[i] = 1 + int'($urandom % 16);
      total   = total + lens[i] + 3;
    end
    limit = 40 * total + 2000;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);

    // Outputs straight out of reset
    check_byte("ulpi_data_o", ulpi_data_o, 8'h00);
    check_byte("ulpi_stp_o", {7'd0, ulpi_stp_o}, 8'h00);
    check_byte("s_tready_o", {7'd0, s_tready_o}, 8'h00);
    check_apb("pready_o", {31'd0, pready_o}, 32'd1);

    // Random packets under random nxt stalls
    for (int i = 0; i < 5; i++) run_packet(lens[i]);

    // Single register write, then status
    a1 = rand_byte();
    d1 = rand_byte();
    apb_write(ulpi_pkg::REG_ADDR, {26'd0, a1[5:0]});
    apb_write(ulpi_pkg::REG_DATA, {24'd0, d1});
    expect_regw(a1[5:0], d1);
    apb_write(ulpi_pkg::REG_GO, 32'd1);
    wait_idle();
    check_status();

    // Second GO while the PHY holds off the first write
    nxt_hold <= 1'b1;
    a1 = rand_byte();
    d1 = rand_byte();
    a2 = rand_byte();
    d2 = rand_byte();
    apb_write(ulpi_pkg::REG_ADDR, {26'd0, a1[5:0]});
    apb_write(ulpi_pkg::REG_DATA, {24'd0, d1});
    expect_regw(a1[5:0], d1);
    apb_write(ulpi_pkg::REG_GO, 32'd1);
    apb_write(ulpi_pkg::REG_ADDR, {26'd0, a2[5:0]});
    apb_write(ulpi_pkg::REG_DATA, {24'd0, d2});
    expect_regw(a2[5:0], d2);
    fork
      apb_access(1'b1, reg_addr(ulpi_pkg::REG_GO), 32'd1, rd, err, waits);
      begin
        repeat (12) @(posedge clock);
        nxt_hold <= 1'b0;
      end
    join
    if (waits == 0) begin
      other_errors++;
      $display("REG_GO write during a busy register write did not stretch pready_o");
    end
    wait_idle();
    check_status();

    // Register request and packet in the same cycle, register goes first
    a1 = rand_byte();
    d1 = rand_byte();
    apb_write(ulpi_pkg::REG_ADDR, {26'd0, a1[5:0]});
    apb_write(ulpi_pkg::REG_DATA, {24'd0, d1});
    make_payload(lens[5]);
    expect_regw(a1[5:0], d1);
    a2 = rand_byte();
    expect_packet(a2[3:0]);
    apb_write(ulpi_pkg::REG_GO, 32'd1);
    send_packet(a2[3:0]);
    wait_idle();

    // Undefined offsets flag an error and leave the registers alone
    apb_access(1'b1, 4'h6, 32'hFFFF_FFFF, rd, err, waits);
    check_apb("pslverr_o", {31'd0, err}, 32'd1);
    apb_access(1'b0, 4'hC, 32'd0, rd, err, waits);
    check_apb("pslverr_o", {31'd0, err}, 32'd1);
    apb_access(1'b0, reg_addr(ulpi_pkg::REG_ADDR), 32'd0, rd, err, waits);
    check_apb("prdata_o", rd, {26'd0, a1[5:0]});
    apb_access(1'b0, reg_addr(ulpi_pkg::REG_DATA), 32'd0, rd, err, waits);
    check_apb("prdata_o", rd, {24'd0, d1});
    check_status();

    repeat (4) @(posedge clock);
    $display("Errors: data %0d, apb %0d, other %0d", data_errors, apb_errors, other_errors);
    if (data_errors + apb_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sim/ulpi_tx_assert.sv */
`timescale 1ns/100ps

module ulpi_tx_assert (
  input logic                clock,
  input logic                reset,
  input logic                stp_i,
  input logic [7:0]          data_i,
  input logic                dir_i,
  input logic                ready_i,
  input ulpi_pkg::tx_state_e state_i
);

  // STP is a single-cycle pulse
  stp_one_cycle: assert property (@(posedge clock) disable iff (reset) stp_i |=> !stp_i)
    else $error("STP held high for more than one cycle");

  // Bus carries 00 while STP is high
  stp_data_zero: assert property (@(posedge clock) disable iff (reset)
    stp_i |-> data_i == 8'h00)
    else $error("ULPI data not 00 during STP");

  // No stream handshake while the PHY owns the bus or has just released it
  ready_low_dir: assert property (@(posedge clock) disable iff (reset)
    (dir_i || $past(dir_i)) |-> !ready_i)
    else $error("Stream ready high during or right after dir");

  // Back in idle once the turnaround ends
  idle_after_turn: assert property (@(posedge clock) disable iff (reset)
    $fell(dir_i) |=> state_i == ulpi_pkg::TX_IDLE)
    else $error("Encoder not idle after dir fell");

endmodule

bind ulpi_tx_encoder ulpi_tx_assert i_assert (
  .clock   (clock),
  .reset   (reset),
  .stp_i   (ulpi_stp_o),
  .data_i  (ulpi_data_o),
  .dir_i   (ulpi_dir_i),
  .ready_i (tx.ready),
  .state_i (state_q)
);

/* source/ulpi_tx_top.sv */
`timescale 1ns/100ps
`include "ulpi_settings.svh"

module ulpi_tx_top (
  input  logic                    clock,
  input  logic                    reset,
  // APB register port
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`ULPI_APB_AW-1:0] paddr_i,
  input  logic [31:0]             pwdata_i,
  output logic [31:0]             prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  // USB packet stream
  input  logic                    s_tvalid_i,
  output logic                    s_tready_o,
  input  logic                    s_tlast_i,
  input  logic [3:0]              s_tpid_i,
  input  logic [7:0]              s_tdata_i,
  // ULPI PHY side
  input  logic [1:0]              line_state_i,
  input  logic                    ulpi_dir_i,
  input  logic                    ulpi_nxt_i,
  output logic                    ulpi_stp_o,
  output logic [7:0]              ulpi_data_o
);

  usb_tx_if  tx_if ();
  phy_req_if req_if ();

  logic       crc_clear, crc_en;
  logic [7:0] crc_byte, crc_hi, crc_lo;

  // Stream ports onto the internal interface
  assign tx_if.valid = s_tvalid_i;
  assign tx_if.last  = s_tlast_i;
  assign tx_if.pid   = s_tpid_i;
  assign tx_if.data  = s_tdata_i;
  assign s_tready_o  = tx_if.ready;

  ulpi_reg_apb i_apb (
    .clock, .reset,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .req (req_if.host)
  );

  ulpi_tx_encoder i_enc (
    .clock, .reset,
    .tx          (tx_if.encoder),
    .req         (req_if.encoder),
    .line_state_i, .ulpi_dir_i, .ulpi_nxt_i,
    .crc_clear_o (crc_clear),
    .crc_byte_o  (crc_byte),
    .crc_en_o    (crc_en),
    .crc_hi_i    (crc_hi),
    .crc_lo_i    (crc_lo),
    .ulpi_stp_o, .ulpi_data_o
  );

  usb_crc16 i_crc (
    .clock, .reset,
    .clear_i  (crc_clear),
    .en_i     (crc_en),
    .byte_i   (crc_byte),
    .crc_lo_o (crc_lo),
    .crc_hi_o (crc_hi)
  );

endmodule

/* source/ulpi_reg_apb.sv */
`timescale 1ns/100ps
`include "ulpi_settings.svh"

module ulpi_reg_apb (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`ULPI_APB_AW-1:0] paddr_i,
  input  logic [31:0]             pwdata_i,
  output logic [31:0]             prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  phy_req_if.host                 req
);

  ulpi_pkg::apb_reg_e sel;

  logic       access, bad, go_wr, stall, wr_en;
  logic       start_q;
  logic [5:0] addr_q;
  logic [7:0] data_q;
  logic [7:0] count_q;

  // Word index, only the first four words exist
  assign access = psel_i && penable_i;
  assign sel    = ulpi_pkg::apb_reg_e'(paddr_i[1:0]);
  assign bad    = paddr_i[`ULPI_APB_AW-1:2] != '0;

  // GO while a write runs waits for done
  assign go_wr     = access && pwrite_i && !bad && sel == ulpi_pkg::REG_GO;
  assign stall     = go_wr && (req.busy || start_q) && !req.done;
  assign pready_o  = !stall;
  assign pslverr_o = access && bad;
  assign wr_en     = access && pwrite_i && !bad && !stall;

  always_ff @(posedge clock) begin
    if (reset) begin
      start_q <= 1'b0;
      addr_q  <= 6'd0;
      data_q  <= 8'd0;
      count_q <= 8'd0;
    end else begin
      start_q <= wr_en && sel == ulpi_pkg::REG_GO;
      if (wr_en && sel == ulpi_pkg::REG_ADDR) begin
        addr_q <= pwdata_i[5:0];
      end
      if (wr_en && sel == ulpi_pkg::REG_DATA) begin
        data_q <= pwdata_i[7:0];
      end
      // Completed writes, wraps at 255
      if (req.done) begin
        count_q <= count_q + 8'd1;
      end
    end
  end

  always_comb begin
    prdata_o = 32'd0;
    if (!bad) begin
      case (sel)
        ulpi_pkg::REG_ADDR:   prdata_o = {26'd0, addr_q};
        ulpi_pkg::REG_DATA:   prdata_o = {24'd0, data_q};
        ulpi_pkg::REG_STATUS: prdata_o = {16'd0, count_q, 7'd0, req.busy};
        default:              prdata_o = 32'd0;
      endcase
    end
  end

  assign req.start = start_q;
  assign req.addr  = addr_q;
  assign req.data  = data_q;

endmodule

/* source/ulpi_tx_encoder.sv */
`timescale 1ns/100ps
`include "ulpi_settings.svh"

module ulpi_tx_encoder (
  input  logic             clock,
  input  logic             reset,
  usb_tx_if.encoder        tx,
  phy_req_if.encoder       req,
  input  logic [1:0]       line_state_i,
  input  logic             ulpi_dir_i,
  input  logic             ulpi_nxt_i,
  output logic             crc_clear_o,
  output logic [7:0]       crc_byte_o,
  output logic             crc_en_o,
  input  logic [7:0]       crc_hi_i,
  input  logic [7:0]       crc_lo_i,
  output logic             ulpi_stp_o,
  output logic [7:0]       ulpi_data_o
);

  ulpi_pkg::tx_state_e state_q;

  logic       dir_q, turn;
  logic       ready_q, take, move, advance;
  logic       out_last_q, got_last_q, last_n;
  logic       reg_phase_q, pend_q, done_q, stp_q;
  logic [7:0] data_q, out_n;
  // Skid byte and its last flag
  logic       skid_vld_q, skid_vld_n, skid_load, skid_used;
  logic [7:0] skid_q, nxt_byte;
  logic       skid_last_q, nxt_last;
  // Register write request, latched on start
  logic [5:0] wr_addr_q, wr_addr;
  logic [7:0] wr_data_q;

  // PHY owns the bus now or did last cycle
  assign turn = ulpi_dir_i || dir_q;

  // Ready is a flop, masked only while the PHY drives
  assign tx.ready = ready_q && !ulpi_dir_i;
  assign take     = tx.valid && tx.ready;

  // Next payload byte, skid first, else straight from the stream
  assign nxt_byte = skid_vld_q ? skid_q : tx.data;
  assign nxt_last = skid_vld_q ? skid_last_q : tx.last;

  // A payload byte moves to the output when nxt takes the current one
  assign move = ulpi_nxt_i && (state_q == ulpi_pkg::TX_XPID ||
                               (state_q == ulpi_pkg::TX_DATA && !out_last_q));
  assign skid_used  = move && skid_vld_q;
  assign skid_load  = take && !(move && !skid_vld_q);
  assign skid_vld_n = skid_load || (skid_vld_q && !skid_used);
  assign last_n     = got_last_q || (take && tx.last);

  // CRC sees every accepted byte, restarts while idle
  assign crc_clear_o = state_q == ulpi_pkg::TX_IDLE;
  assign crc_en_o    = take;
  assign crc_byte_o  = tx.data;

  assign wr_addr  = req.start ? req.addr : wr_addr_q;
  assign req.busy = pend_q || state_q == ulpi_pkg::TX_REGW || state_q == ulpi_pkg::TX_RSTP;
  assign req.done = done_q;

  // Output byte changes in idle or when the PHY took the current byte
  assign advance = state_q == ulpi_pkg::TX_IDLE ||
                   (ulpi_nxt_i && state_q inside {ulpi_pkg::TX_XPID, ulpi_pkg::TX_DATA,
                                                  ulpi_pkg::TX_CRC0, ulpi_pkg::TX_CRC1,
                                                  ulpi_pkg::TX_REGW});

  // Output mux over TX command, payload, CRC and register bytes
  always_comb begin
    out_n = 8'h00;
    case (state_q)
      ulpi_pkg::TX_IDLE: begin
        // Register write has priority over a waiting packet
        if (req.start || pend_q) begin
          out_n = {ulpi_pkg::CMD_REGW, wr_addr};
        end else if (tx.valid) begin
          out_n = {ulpi_pkg::CMD_TX, 2'b00, tx.pid};
        end
      end
      ulpi_pkg::TX_XPID: out_n = nxt_byte;
      ulpi_pkg::TX_DATA: out_n = out_last_q ? crc_lo_i : nxt_byte;
      ulpi_pkg::TX_CRC0: out_n = crc_hi_i;
      ulpi_pkg::TX_REGW: out_n = reg_phase_q ? 8'h00 : wr_data_q;
      default: out_n = 8'h00;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q     <= ulpi_pkg::TX_IDLE;
      dir_q       <= 1'b0;
      ready_q     <= 1'b0;
      skid_vld_q  <= 1'b0;
      out_last_q  <= 1'b0;
      got_last_q  <= 1'b0;
      reg_phase_q <= 1'b0;
      pend_q      <= 1'b0;
      done_q      <= 1'b0;
      stp_q       <= 1'b0;
      data_q      <= 8'h00;
    end else begin
      dir_q  <= ulpi_dir_i;
      done_q <= 1'b0;
      stp_q  <= 1'b0;
      if (req.start) begin
        pend_q <= 1'b1;
      end
      // Turnaround aborts everything except the EOP wait
      if (turn && state_q != ulpi_pkg::TX_EOP) begin
        state_q     <= ulpi_pkg::TX_IDLE;
        data_q      <= 8'h00;
        ready_q     <= 1'b0;
        skid_vld_q  <= 1'b0;
        got_last_q  <= 1'b0;
        reg_phase_q <= 1'b0;
        // Retry an interrupted register write
        if (state_q == ulpi_pkg::TX_REGW) begin
          pend_q <= 1'b1;
        end
      end else begin
        if (advance) begin
          data_q <= out_n;
        end
        case (state_q)
          ulpi_pkg::TX_IDLE: begin
            if (req.start || pend_q) begin
              state_q     <= ulpi_pkg::TX_REGW;
              pend_q      <= 1'b0;
              reg_phase_q <= 1'b0;
            end else if (tx.valid) begin
              state_q    <= ulpi_pkg::TX_XPID;
              ready_q    <= 1'b1;
              got_last_q <= 1'b0;
            end
          end
          ulpi_pkg::TX_XPID, ulpi_pkg::TX_DATA: begin
            // Stop accepting once the skid is full or last is in
            ready_q    <= !skid_vld_n && !last_n;
            skid_vld_q <= skid_vld_n;
            got_last_q <= last_n;
            if (move) begin
              out_last_q <= nxt_last;
            end
            if (ulpi_nxt_i && state_q == ulpi_pkg::TX_XPID) begin
              state_q <= ulpi_pkg::TX_DATA;
            end
            if (ulpi_nxt_i && state_q == ulpi_pkg::TX_DATA && out_last_q) begin
              state_q <= ulpi_pkg::TX_CRC0;
            end
          end
          ulpi_pkg::TX_CRC0: begin
            if (ulpi_nxt_i) begin
              state_q <= ulpi_pkg::TX_CRC1;
            end
          end
          ulpi_pkg::TX_CRC1: begin
            if (ulpi_nxt_i) begin
              state_q <= ulpi_pkg::TX_STOP;
              stp_q   <= 1'b1;
            end
          end
          ulpi_pkg::TX_STOP: state_q <= ulpi_pkg::TX_EOP;
          ulpi_pkg::TX_EOP: begin
            // PHY reports SE0 for two cycles with nxt low
            if (ulpi_dir_i && dir_q && !ulpi_nxt_i && line_state_i == `ULPI_EOP_LS) begin
              state_q <= ulpi_pkg::TX_IDLE;
            end
          end
          ulpi_pkg::TX_REGW: begin
            // First nxt takes the command, second takes the data
            if (ulpi_nxt_i && reg_phase_q) begin
              state_q <= ulpi_pkg::TX_RSTP;
              stp_q   <= 1'b1;
              done_q  <= 1'b1;
            end else if (ulpi_nxt_i) begin
              reg_phase_q <= 1'b1;
            end
          end
          default: state_q <= ulpi_pkg::TX_IDLE;
        endcase
      end
    end
  end

  // Payload registers
  always_ff @(posedge clock) begin
    if (skid_load) begin
      skid_q      <= tx.data;
      skid_last_q <= tx.last;
    end
    if (req.start) begin
      wr_addr_q <= req.addr;
      wr_data_q <= req.data;
    end
  end

  assign ulpi_stp_o  = stp_q;
  assign ulpi_data_o = data_q;

endmodule

/* source/usb_crc16.sv */
`timescale 1ns/100ps
`include "ulpi_settings.svh"

module usb_crc16 (
  input  logic       clock,
  input  logic       reset,
  input  logic       clear_i,
  input  logic       en_i,
  input  logic [7:0] byte_i,
  output logic [7:0] crc_lo_o,
  output logic [7:0] crc_hi_o
);

  logic [15:0] crc_q;
  logic [15:0] crc_tx;

  // Polynomial 8005, data bits shifted in LSB first
  function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[15] ^ b[i];
      c  = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ 16'h8005;
      end
    end
    return c;
  endfunction

  // Clear wins, a byte on the same edge is dropped
  always_ff @(posedge clock) begin
    if (reset || clear_i) begin
      crc_q <= `ULPI_CRC_SEED;
    end else if (en_i) begin
      crc_q <= crc_step(crc_q, byte_i);
    end
  end

  // Remainder goes out inverted and bit-reversed
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      crc_tx[i] = ~crc_q[15-i];
    end
  end

  // Low byte is sent first
  assign crc_lo_o = crc_tx[7:0];
  assign crc_hi_o = crc_tx[15:8];

endmodule

/* source/ulpi_if.sv */
`timescale 1ns/100ps

// Packet byte stream into the encoder
interface usb_tx_if;
  logic       valid;
  logic       ready;
  logic       last;
  // PID only meaningful with the first byte of a packet
  logic [3:0] pid;
  logic [7:0] data;

  modport source(output valid, output last, output pid, output data, input ready);
  modport encoder(input valid, input last, input pid, input data, output ready);
endinterface

// PHY register write request
interface phy_req_if;
  // One-cycle pulse from the register block
  logic       start;
  logic [5:0] addr;
  logic [7:0] data;
  // Write pending or running in the encoder
  logic       busy;
  // One-cycle pulse once the PHY took the data byte
  logic       done;

  modport host(output start, output addr, output data, input busy, input done);
  modport encoder(input start, input addr, input data, output busy, output done);
endinterface

/* source/ulpi_pkg.sv */
`include "ulpi_settings.svh"

package ulpi_pkg;

  // Transmit FSM states
  typedef enum logic [3:0] {
    TX_IDLE,
    TX_XPID,
    TX_DATA,
    TX_CRC0,
    TX_CRC1,
    TX_STOP,
    TX_EOP,
    TX_REGW,
    TX_RSTP
  } tx_state_e;

  // Command field of a ULPI command byte
  typedef enum logic [1:0] {
    CMD_NOOP = `ULPI_CMD_NOOP,
    CMD_TX   = `ULPI_CMD_TX,
    CMD_REGW = `ULPI_CMD_REGW
  } ulpi_cmd_e;

  // APB register map
  typedef enum logic [1:0] {
    REG_ADDR   = `ULPI_REG_ADDR,
    REG_DATA   = `ULPI_REG_DATA,
    REG_GO     = `ULPI_REG_GO,
    REG_STATUS = `ULPI_REG_STATUS
  } apb_reg_e;

endpackage

/* include/ulpi_settings.svh */
`ifndef ULPI_SETTINGS_SVH
`define ULPI_SETTINGS_SVH

// Upper two bits of a ULPI command byte
`define ULPI_CMD_NOOP 2'b00
`define ULPI_CMD_TX 2'b01
`define ULPI_CMD_REGW 2'b10

// APB register word offsets, paddr is a word index
`define ULPI_APB_AW 4
`define ULPI_REG_ADDR 2'd0
`define ULPI_REG_DATA 2'd1
`define ULPI_REG_GO 2'd2
`define ULPI_REG_STATUS 2'd3

// USB CRC16 start value
`define ULPI_CRC_SEED 16'hFFFF

// Line state reported by the PHY at end of packet (SE0)
`define ULPI_EOP_LS 2'b00

`endif
